// ==== hdl/arithPkg.sv ====
package arithPkg;

  ////////////////////
  // Widths

  // Byte-wide command and data ports
  localparam int ByteWidth = 8;
  // Operand registers and adder
  localparam int WordWidth = 16;
  // One shift-and-add step per multiplier bit
  localparam int MulSteps = ByteWidth;

  typedef logic [ByteWidth-1:0] byte_t;
  typedef logic [WordWidth-1:0] word_t;
  typedef logic [2:0] stepCount_t;

  ////////////////////
  // Command encodings

  typedef logic [1:0] opcode_t;

  localparam opcode_t OpLoad = 2'd0;
  localparam opcode_t OpAdd = 2'd1;
  localparam opcode_t OpSub = 2'd2;
  localparam opcode_t OpMul = 2'd3;

  // Register byte select, shared by loads and the read mux
  typedef logic [1:0] regSel_t;

  localparam regSel_t SelALow = 2'd0;
  localparam regSel_t SelAHigh = 2'd1;
  localparam regSel_t SelBLow = 2'd2;
  localparam regSel_t SelBHigh = 2'd3;

  ////////////////////
  // Control FSM

  typedef enum logic [1:0]
  {
    Idle,
    Apply,
    AddSub,
    Multiply
  } ctrlState_e;

endpackage

// ==== hdl/cmdControl.sv ====
`timescale 1ns/1ps

module cmdControl
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  arithPkg::opcode_t opcode,
  input  arithPkg::regSel_t regSel,
  input  logic              write,
  input  logic              useRegA,
  input  logic              signedMode,
  input  arithPkg::byte_t   dataIn,
  input  logic              lastStep,
  output arithPkg::byte_t   latchedByte,
  output arithPkg::regSel_t latchedSel,
  output logic              latchedUseA,
  output logic              latchedSigned,
  output logic              loadByte,
  output logic              setReadSel,
  output logic              mulInit,
  output logic              mulStep,
  output logic              mulActive,
  output logic              subtract,
  output logic              writeB,
  output logic              setFlags,
  output logic              busy,
  output logic              done,
  output logic              error
);

  arithPkg::ctrlState_e state;
  arithPkg::ctrlState_e stateNext;
  arithPkg::opcode_t    latchedOp;
  logic                 latchedWrite;
  logic                 applyLoad;
  logic                 finalStep;

  ////////////////////
  // Command latch

  // A start outside Idle is dropped
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      latchedOp     <= arithPkg::OpLoad;
      latchedSel    <= arithPkg::SelALow;
      latchedByte   <= '0;
      latchedWrite  <= 1'b0;
      latchedUseA   <= 1'b0;
      latchedSigned <= 1'b0;
    end
    else if (start && state == arithPkg::Idle)
    begin
      latchedOp     <= opcode;
      latchedSel    <= regSel;
      latchedByte   <= dataIn;
      latchedWrite  <= write;
      latchedUseA   <= useRegA;
      latchedSigned <= signedMode;
    end
  end

  ////////////////////
  // Sequencer

  always_comb
  begin
    stateNext = state;
    case (state)
      arithPkg::Idle:
      begin
        if (start)
          stateNext = arithPkg::Apply;
      end
      arithPkg::Apply:
      begin
        case (latchedOp)
          arithPkg::OpLoad: stateNext = arithPkg::Idle;
          arithPkg::OpMul:  stateNext = arithPkg::Multiply;
          default:          stateNext = arithPkg::AddSub;
        endcase
      end
      arithPkg::AddSub:
        stateNext = arithPkg::Idle;
      arithPkg::Multiply:
      begin
        if (lastStep)
          stateNext = arithPkg::Idle;
      end
      default:
        stateNext = arithPkg::Idle;
    endcase
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
      state <= arithPkg::Idle;
    else
      state <= stateNext;
  end

  // Strobes decoded from state
  assign applyLoad = (state == arithPkg::Apply) && (latchedOp == arithPkg::OpLoad);
  assign loadByte = applyLoad && latchedWrite;
  assign setReadSel = applyLoad && !latchedWrite;
  assign mulInit = (state == arithPkg::Apply) && (latchedOp == arithPkg::OpMul);
  assign mulActive = (state == arithPkg::Multiply);
  assign mulStep = mulActive;
  assign finalStep = mulActive && lastStep;
  assign writeB = (state == arithPkg::AddSub) || mulActive;
  assign setFlags = (state == arithPkg::AddSub) || finalStep;

  // Signed multiply weights the top multiplier bit negatively
  assign subtract = ((state == arithPkg::AddSub) && (latchedOp == arithPkg::OpSub)) ||
                    (finalStep && latchedSigned);

  assign busy = (state == arithPkg::AddSub) || mulActive;

  ////////////////////
  // Done and error

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      done  <= 1'b0;
      error <= 1'b0;
    end
    else
    begin
      done <= applyLoad || (state == arithPkg::AddSub) || finalStep;
      // Sticky until reset
      if (busy && (signedMode != latchedSigned))
        error <= 1'b1;
    end
  end

endmodule

// ==== hdl/mulStepper.sv ====
`timescale 1ns/1ps

module mulStepper
(
  input  logic            CLK,
  input  logic            RST,
  input  logic            mulInit,
  input  logic            mulStep,
  input  arithPkg::word_t regA,
  input  arithPkg::byte_t latchedByte,
  output arithPkg::word_t addend,
  output logic            lastStep
);

  // Multiplicand shadow, A shifted left by the step index
  arithPkg::word_t      shadow;
  // Remaining multiplier bits, current bit at the bottom
  arithPkg::byte_t      multiplier;
  arithPkg::stepCount_t stepCount;

  ////////////////////
  // Step registers

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      shadow     <= '0;
      multiplier <= '0;
      stepCount  <= '0;
    end
    else if (mulInit)
    begin
      shadow     <= regA;
      multiplier <= latchedByte;
      stepCount  <= '0;
    end
    else if (mulStep)
    begin
      shadow     <= shadow << 1;
      multiplier <= multiplier >> 1;
      stepCount  <= stepCount + 3'd1;
    end
  end

  // Partial product for this step
  assign addend = multiplier[0] ? shadow : '0;

  assign lastStep = (stepCount == arithPkg::stepCount_t'(arithPkg::MulSteps - 1));

endmodule

// ==== hdl/addSubUnit.sv ====
`timescale 1ns/1ps

module addSubUnit
(
  input  arithPkg::word_t accum,
  input  arithPkg::word_t regA,
  input  arithPkg::byte_t latchedByte,
  input  arithPkg::word_t stepAddend,
  input  logic            mulActive,
  input  logic            useA,
  input  logic            signedMode,
  input  logic            subtract,
  output arithPkg::word_t sum,
  output logic            overflow,
  output logic            negative
);

  localparam int Msb = arithPkg::WordWidth - 1;

  arithPkg::word_t extByte;
  arithPkg::word_t operand;
  arithPkg::word_t addend;
  logic            carryOut;

  ////////////////////
  // Operand select

  assign extByte = {{(arithPkg::WordWidth - arithPkg::ByteWidth)
                     {signedMode & latchedByte[arithPkg::ByteWidth-1]}}, latchedByte};
  assign operand = mulActive ? stepAddend : (useA ? regA : extByte);

  // Subtract as invert plus carry-in
  assign addend = subtract ? ~operand : operand;
  assign {carryOut, sum} = {1'b0, accum} + {1'b0, addend} +
                           {{arithPkg::WordWidth{1'b0}}, subtract};

  ////////////////////
  // Flags

  always_comb
  begin
    if (mulActive)
    begin
      overflow = 1'b0;
      negative = signedMode & sum[Msb];
    end
    else if (signedMode)
    begin
      // Same-sign inputs, different-sign result
      overflow = (accum[Msb] == addend[Msb]) && (sum[Msb] != accum[Msb]);
      negative = sum[Msb];
    end
    else
    begin
      // Borrow is the missing carry
      overflow = subtract ? ~carryOut : carryOut;
      negative = subtract & ~carryOut;
    end
  end

endmodule

// ==== hdl/operandRegs.sv ====
`timescale 1ns/1ps

module operandRegs
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              loadByte,
  input  logic              setReadSel,
  input  logic              writeB,
  input  logic              setFlags,
  input  arithPkg::regSel_t latchedSel,
  input  arithPkg::byte_t   latchedByte,
  input  arithPkg::word_t   sum,
  input  logic              sumOverflow,
  input  logic              sumNegative,
  output arithPkg::word_t   regA,
  output arithPkg::word_t   regB,
  output arithPkg::byte_t   dataOut,
  output logic              overflow,
  output logic              negative
);

  localparam int LowMsb = arithPkg::ByteWidth - 1;
  localparam int HighLsb = arithPkg::ByteWidth;
  localparam int HighMsb = arithPkg::WordWidth - 1;

  arithPkg::regSel_t readSel;
  arithPkg::regSel_t readSelNext;
  arithPkg::word_t   aNext;
  arithPkg::word_t   bNext;
  arithPkg::byte_t   dataOutNext;

  ////////////////////
  // Next register values

  always_comb
  begin
    aNext = regA;
    bNext = regB;
    readSelNext = readSel;
    if (loadByte)
    begin
      case (latchedSel)
        arithPkg::SelALow:  aNext[LowMsb:0] = latchedByte;
        arithPkg::SelAHigh: aNext[HighMsb:HighLsb] = latchedByte;
        arithPkg::SelBLow:  bNext[LowMsb:0] = latchedByte;
        default:            bNext[HighMsb:HighLsb] = latchedByte;
      endcase
    end
    if (writeB)
      bNext = sum;
    if (setReadSel)
      readSelNext = latchedSel;
  end

  // Output mux looks at next values so dataOut tracks the registers
  always_comb
  begin
    case (readSelNext)
      arithPkg::SelALow:  dataOutNext = aNext[LowMsb:0];
      arithPkg::SelAHigh: dataOutNext = aNext[HighMsb:HighLsb];
      arithPkg::SelBLow:  dataOutNext = bNext[LowMsb:0];
      default:            dataOutNext = bNext[HighMsb:HighLsb];
    endcase
  end

  ////////////////////
  // Registers

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      regA    <= '0;
      regB    <= '0;
      readSel <= arithPkg::SelALow;
      dataOut <= '0;
    end
    else
    begin
      regA    <= aNext;
      regB    <= bNext;
      readSel <= readSelNext;
      dataOut <= dataOutNext;
    end
  end

  // Flags hold until the next arithmetic result
  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      overflow <= 1'b0;
      negative <= 1'b0;
    end
    else if (setFlags)
    begin
      overflow <= sumOverflow;
      negative <= sumNegative;
    end
  end

endmodule

// ==== hdl/arithCoreTop.sv ====
`timescale 1ns/1ps

module arithCoreTop
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  arithPkg::opcode_t opcode,
  input  arithPkg::regSel_t regSel,
  input  logic              write,
  input  logic              useRegA,
  input  logic              signedMode,
  input  arithPkg::byte_t   dataIn,
  output arithPkg::byte_t   dataOut,
  output logic              overflow,
  output logic              negative,
  output logic              busy,
  output logic              done,
  output logic              error
);

  // Latched command fields
  arithPkg::byte_t   latchedByte;
  arithPkg::regSel_t latchedSel;
  logic              latchedUseA;
  logic              latchedSigned;

  // Control strobes
  logic loadByte;
  logic setReadSel;
  logic mulInit;
  logic mulStep;
  logic mulActive;
  logic subtract;
  logic writeB;
  logic setFlags;
  logic lastStep;

  // Datapath
  arithPkg::word_t regA;
  arithPkg::word_t regB;
  arithPkg::word_t stepAddend;
  arithPkg::word_t sum;
  logic            sumOverflow;
  logic            sumNegative;

  ////////////////////
  // Control

  cmdControl u_cmdControl
  (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .opcode        (opcode),
    .regSel        (regSel),
    .write         (write),
    .useRegA       (useRegA),
    .signedMode    (signedMode),
    .dataIn        (dataIn),
    .lastStep      (lastStep),
    .latchedByte   (latchedByte),
    .latchedSel    (latchedSel),
    .latchedUseA   (latchedUseA),
    .latchedSigned (latchedSigned),
    .loadByte      (loadByte),
    .setReadSel    (setReadSel),
    .mulInit       (mulInit),
    .mulStep       (mulStep),
    .mulActive     (mulActive),
    .subtract      (subtract),
    .writeB        (writeB),
    .setFlags      (setFlags),
    .busy          (busy),
    .done          (done),
    .error         (error)
  );

  ////////////////////
  // Datapath

  mulStepper u_mulStepper
  (
    .CLK         (CLK),
    .RST         (RST),
    .mulInit     (mulInit),
    .mulStep     (mulStep),
    .regA        (regA),
    .latchedByte (latchedByte),
    .addend      (stepAddend),
    .lastStep    (lastStep)
  );

  // B is always the accumulator of the shared adder
  addSubUnit u_addSubUnit
  (
    .accum       (regB),
    .regA        (regA),
    .latchedByte (latchedByte),
    .stepAddend  (stepAddend),
    .mulActive   (mulActive),
    .useA        (latchedUseA),
    .signedMode  (latchedSigned),
    .subtract    (subtract),
    .sum         (sum),
    .overflow    (sumOverflow),
    .negative    (sumNegative)
  );

  operandRegs u_operandRegs
  (
    .CLK         (CLK),
    .RST         (RST),
    .loadByte    (loadByte),
    .setReadSel  (setReadSel),
    .writeB      (writeB),
    .setFlags    (setFlags),
    .latchedSel  (latchedSel),
    .latchedByte (latchedByte),
    .sum         (sum),
    .sumOverflow (sumOverflow),
    .sumNegative (sumNegative),
    .regA        (regA),
    .regB        (regB),
    .dataOut     (dataOut),
    .overflow    (overflow),
    .negative    (negative)
  );

endmodule

// ==== sim/arithCoreTb.sv ====
`timescale 1ns/1ps

module arithCoreTb;

  localparam int NumLoads = 40;
  localparam int NumAddSub = 40;
  localparam int NumUseA = 20;
  localparam int NumMul = 40;
  localparam int NumBusy = 8;
  // Edge values and the error sequence add eight more cases
  localparam int NumCases = NumAddSub + NumUseA + NumMul + NumBusy + 8;
  // Each case loads A and B, runs one operation and reads four bytes back
  localparam int NumCommands = NumLoads + 8 + 9 * NumCases;
  localparam int WatchdogCycles = NumCommands * 12 + 200;
  localparam int DoneTimeout = 20;

  logic              CLK;
  logic              RST;
  logic              start;
  arithPkg::opcode_t opcode;
  arithPkg::regSel_t regSel;
  logic              write;
  logic              useRegA;
  logic              signedMode;
  arithPkg::byte_t   dataIn;
  arithPkg::byte_t   dataOut;
  logic              overflow;
  logic              negative;
  logic              busy;
  logic              done;
  logic              error;

  logic [31:0] seed;

  // Reference model state
  logic [15:0]       mA;
  logic [15:0]       mB;
  arithPkg::regSel_t mSel;
  logic              mOv;
  logic              mNeg;
  logic              mErr;

  arithCoreTop u_arithCoreTop
  (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .opcode     (opcode),
    .regSel     (regSel),
    .write      (write),
    .useRegA    (useRegA),
    .signedMode (signedMode),
    .dataIn     (dataIn),
    .dataOut    (dataOut),
    .overflow   (overflow),
    .negative   (negative),
    .busy       (busy),
    .done       (done),
    .error      (error)
  );

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////
  // Helpers

  function automatic logic [15:0] randWord();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[31:16];
  endfunction

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    assert (got === expected)
    else
      failRun($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, expected));
  endtask

  function automatic arithPkg::byte_t modelByte(input arithPkg::regSel_t s);
    case (s)
      arithPkg::SelALow:  return mA[7:0];
      arithPkg::SelAHigh: return mA[15:8];
      arithPkg::SelBLow:  return mB[7:0];
      default:            return mB[15:8];
    endcase
  endfunction

  ////////////////////
  // Reference model

  task automatic applyModel(input arithPkg::opcode_t op, input arithPkg::regSel_t sel,
                            input logic wr, input logic useA, input logic sgn,
                            input arithPkg::byte_t data);
    logic [15:0] operand;
    logic [16:0] wide;
    logic [15:0] res;
    int          mult;
    int          prod;
    operand = useA ? mA : (sgn ? {{8{data[7]}}, data} : {8'h00, data});
    case (op)
      arithPkg::OpLoad:
      begin
        if (!wr)
          mSel = sel;
        else if (sel == arithPkg::SelALow)
          mA[7:0] = data;
        else if (sel == arithPkg::SelAHigh)
          mA[15:8] = data;
        else if (sel == arithPkg::SelBLow)
          mB[7:0] = data;
        else
          mB[15:8] = data;
      end
      arithPkg::OpAdd:
      begin
        wide = {1'b0, mB} + {1'b0, operand};
        res = wide[15:0];
        mOv = sgn ? ((mB[15] == operand[15]) && (res[15] != mB[15])) : wide[16];
        mNeg = sgn ? res[15] : 1'b0;
        mB = res;
      end
      arithPkg::OpSub:
      begin
        res = mB - operand;
        // Unsigned mode reports the borrow on both flags
        mOv = sgn ? ((mB[15] != operand[15]) && (res[15] != mB[15])) : (mB < operand);
        mNeg = sgn ? res[15] : (mB < operand);
        mB = res;
      end
      default:
      begin
        mult = sgn ? int'($signed(data)) : int'(data);
        prod = int'(mA) * mult;
        res = mB + prod[15:0];
        mOv = 1'b0;
        mNeg = sgn & res[15];
        mB = res;
      end
    endcase
  endtask

  ////////////////////
  // Command driver

  // Negative toggleAt or restartAt means no disturbance
  task automatic runCommand(input arithPkg::opcode_t op, input arithPkg::regSel_t sel,
                            input logic wr, input logic useA, input logic sgn,
                            input arithPkg::byte_t data, input int toggleAt,
                            input int restartAt);
    int          k;
    int          lat;
    logic [15:0] r;
    lat = (op == arithPkg::OpLoad) ? 1 : ((op == arithPkg::OpMul) ? arithPkg::MulSteps + 1 : 2);
    applyModel(op, sel, wr, useA, sgn, data);
    if (op != arithPkg::OpLoad && toggleAt >= 1 && toggleAt < lat)
      mErr = 1'b1;
    @(negedge CLK);
    start = 1'b1;
    opcode = op;
    regSel = sel;
    write = wr;
    useRegA = useA;
    signedMode = sgn;
    dataIn = data;
    @(negedge CLK);
    start = 1'b0;
    k = 0;
    while (done !== 1'b1)
    begin
      checkValue("busy", busy, (k > 0) && (op != arithPkg::OpLoad));
      if (k == toggleAt)
        signedMode = ~signedMode;
      if (k == restartAt)
      begin
        // Stray command that must be dropped
        r = randWord();
        start = 1'b1;
        opcode = arithPkg::opcode_t'(r[1:0]);
        regSel = arithPkg::regSel_t'(r[3:2]);
        write = 1'b1;
        useRegA = r[4];
        dataIn = r[15:8];
      end
      @(negedge CLK);
      start = 1'b0;
      k++;
      if (k > DoneTimeout)
        failRun("done never rose after a command was issued");
    end
    checkValue("latency", k, lat);
    checkValue("busy", busy, 1'b0);
    checkValue("dataOut", dataOut, modelByte(mSel));
    checkValue("overflow", overflow, mOv);
    checkValue("negative", negative, mNeg);
    checkValue("error", error, mErr);
    @(negedge CLK);
    checkValue("done", done, 1'b0);
  endtask

  task automatic setRegs(input logic [15:0] a, input logic [15:0] b);
    runCommand(arithPkg::OpLoad, arithPkg::SelALow, 1'b1, 1'b0, 1'b0, a[7:0], -1, -1);
    runCommand(arithPkg::OpLoad, arithPkg::SelAHigh, 1'b1, 1'b0, 1'b0, a[15:8], -1, -1);
    runCommand(arithPkg::OpLoad, arithPkg::SelBLow, 1'b1, 1'b0, 1'b0, b[7:0], -1, -1);
    runCommand(arithPkg::OpLoad, arithPkg::SelBHigh, 1'b1, 1'b0, 1'b0, b[15:8], -1, -1);
  endtask

  task automatic readBack();
    for (int s = 0; s < 4; s++)
      runCommand(arithPkg::OpLoad, arithPkg::regSel_t'(s), 1'b0, 1'b0, 1'b0, 8'h00, -1, -1);
  endtask

  task automatic arithCase(input logic [15:0] a, input logic [15:0] b,
                           input arithPkg::opcode_t op, input logic useA, input logic sgn,
                           input arithPkg::byte_t data, input int toggleAt,
                           input int restartAt);
    setRegs(a, b);
    runCommand(op, arithPkg::SelBLow, 1'b0, useA, sgn, data, toggleAt, restartAt);
    readBack();
  endtask

  task automatic resetDut();
    RST = 1'b0;
    mA = '0;
    mB = '0;
    mSel = arithPkg::SelALow;
    mOv = 1'b0;
    mNeg = 1'b0;
    mErr = 1'b0;
    repeat (2) @(negedge CLK);
    RST = 1'b1;
    checkValue("busy", busy, 1'b0);
    checkValue("done", done, 1'b0);
    checkValue("error", error, 1'b0);
    checkValue("overflow", overflow, 1'b0);
    checkValue("negative", negative, 1'b0);
    checkValue("dataOut", dataOut, 8'h00);
  endtask

  ////////////////////
  // Main sequence

  initial
  begin
    logic [15:0]       r;
    arithPkg::opcode_t op;
    start = 1'b0;
    opcode = arithPkg::OpLoad;
    regSel = arithPkg::SelALow;
    write = 1'b0;
    useRegA = 1'b0;
    signedMode = 1'b0;
    dataIn = '0;
    seed = 32'd57;
    resetDut();

    // Random byte writes mixed with read selects
    for (int i = 0; i < NumLoads; i++)
    begin
      r = randWord();
      runCommand(arithPkg::OpLoad, arithPkg::regSel_t'(r[1:0]), r[2], 1'b0, r[3],
                 r[15:8], -1, -1);
    end
    readBack();

    // Byte operand in both modes
    for (int i = 0; i < NumAddSub; i++)
    begin
      r = randWord();
      arithCase(randWord(), randWord(), r[0] ? arithPkg::OpSub : arithPkg::OpAdd, 1'b0, r[1],
                r[15:8], -1, -1);
    end
    arithCase(16'h0000, 16'h7FFF, arithPkg::OpAdd, 1'b0, 1'b1, 8'h01, -1, -1);
    arithCase(16'h0000, 16'h0000, arithPkg::OpSub, 1'b0, 1'b0, 8'h01, -1, -1);
    arithCase(16'h0000, 16'h0000, arithPkg::OpSub, 1'b0, 1'b1, 8'h01, -1, -1);
    arithCase(16'h0000, 16'hFFFF, arithPkg::OpAdd, 1'b0, 1'b0, 8'h01, -1, -1);
    arithCase(16'h0001, 16'h8000, arithPkg::OpSub, 1'b1, 1'b1, 8'h00, -1, -1);

    // Register A as operand
    for (int i = 0; i < NumUseA; i++)
    begin
      r = randWord();
      arithCase(randWord(), randWord(), r[0] ? arithPkg::OpSub : arithPkg::OpAdd, 1'b1, r[1],
                r[15:8], -1, -1);
    end

    // Multiply-accumulate
    for (int i = 0; i < NumMul; i++)
    begin
      r = randWord();
      arithCase(randWord(), randWord(), arithPkg::OpMul, r[2], r[1], r[15:8], -1, -1);
    end

    // Start strobes while busy
    for (int i = 0; i < NumBusy; i++)
    begin
      r = randWord();
      op = r[0] ? arithPkg::OpMul : (r[1] ? arithPkg::OpSub : arithPkg::OpAdd);
      arithCase(randWord(), randWord(), op, r[5], r[6], r[15:8], -1,
                (op == arithPkg::OpMul) ? 1 + int'(r[4:2]) : 1);
    end

    // Mode changes while idle are harmless
    repeat (4)
    begin
      @(negedge CLK);
      signedMode = ~signedMode;
    end
    @(negedge CLK);
    checkValue("error", error, mErr);

    // Mode change mid multiply sets the sticky error
    r = randWord();
    arithCase(randWord(), randWord(), arithPkg::OpMul, 1'b0, 1'b0, r[7:0], 4, -1);
    checkValue("error", error, 1'b1);
    arithCase(randWord(), randWord(), arithPkg::OpAdd, 1'b0, 1'b1, r[15:8], -1, -1);
    arithCase(randWord(), randWord(), arithPkg::OpMul, 1'b0, 1'b1, r[11:4], -1, -1);
    checkValue("error", error, 1'b1);
    resetDut();
    readBack();

    $display("Simulation passed");
    $finish;
  end

  // Watchdog sized from the command count
  initial
  begin
    repeat (WatchdogCycles) @(posedge CLK);
    failRun("watchdog expired before the tests finished");
  end

endmodule

// ==== build.f ====
hdl/arithPkg.sv
hdl/cmdControl.sv
hdl/mulStepper.sv
hdl/addSubUnit.sv
hdl/operandRegs.sv
hdl/arithCoreTop.sv
sim/arithCoreTb.sv
